// File: Makefile
# Verilator build of the board I/O shell and its testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_sonata_io
FILELIST  ?= sonata_io.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

SRCS := $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator exits non-zero on any failed check
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: design/board_gpio_map.sv
////////////////////////////////////////////////////////////////////////////
// Board GPIO mapping: switch inversion and GPIO word packing, output
// word unpacking, SPI chip-select routing and the status LEDs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sonata_io_cfg.svh"

module board_gpio_map (
  input  sonata_io_pkg::board_sw_t   sw_n_i,
  input  logic                       mb_int_i,
  input  sonata_io_pkg::gp_out_t     gp_o_i,
  input  sonata_io_pkg::spi_cs_t     spi_cs_i,
  input  logic                       cheri_en_i,
  input  logic                       rgbled_dout_i,
  input  logic                       rst_sys_n_i,
  output logic [`SONATA_GPI_W-1:0]   gp_i_o,
  output sonata_io_pkg::board_cs_t   cs_pins_o,
  output sonata_io_pkg::status_led_t led_o,
  output logic [7:0]                 user_led_o,
  output logic [2:0]                 lcd_ctrl_o,     // {backlight, dc, rst}
  output logic                       eth_rst_o,
  output logic                       mb_rst_o,
  output logic                       flash_wp_n_o,
  output logic                       flash_hold_n_o,
  output logic                       rgbled_o
);
  import sonata_io_pkg::*;

  // Switches plus the mikroBUS interrupt
  localparam int unsigned GpiUsed = $bits(board_sw_t) + 1;

  board_sw_t sw_on;

  // Switches pull to ground when closed, so 1 means pressed after this
  assign sw_on = board_sw_t'(~sw_n_i);

  assign gp_i_o = {
    {(`SONATA_GPI_W - GpiUsed){1'b0}},
    sw_on.sel,
    mb_int_i,     // mikroBUS Click interrupt
    sw_on.user,
    sw_on.nav
  };

  // Output word fields to their pins
  assign user_led_o = gp_o_i.user_led;
  assign lcd_ctrl_o = {gp_o_i.lcd_backlight, gp_o_i.lcd_dc, gp_o_i.lcd_rst};
  assign eth_rst_o  = gp_o_i.eth_rst;
  assign mb_rst_o   = gp_o_i.mb_rst;

  // Chip selects, other controller lines are left open
  always_comb begin
    cs_pins_o.flash_cs     = spi_cs_i[SPI_FLASH][0];
    cs_pins_o.lcd_cs       = spi_cs_i[SPI_LCD][0];
    cs_pins_o.eth_cs       = spi_cs_i[SPI_ETH][0];
    cs_pins_o.rph_ce0      = spi_cs_i[SPI_RPH0][0];
    cs_pins_o.rph_ce1      = spi_cs_i[SPI_RPH0][1];
    cs_pins_o.ard_cs       = spi_cs_i[SPI_RPH0][2];
    cs_pins_o.rph_spi1_ce0 = spi_cs_i[SPI_RPH1][0];
    cs_pins_o.rph_spi1_ce1 = spi_cs_i[SPI_RPH1][1];
    cs_pins_o.rph_spi1_ce2 = spi_cs_i[SPI_RPH1][2];
    cs_pins_o.mb_cs        = spi_cs_i[SPI_RPH1][3];
  end

  // Status LEDs
  assign led_o.bootok = rst_sys_n_i;   // Lit once out of reset
  assign led_o.halted = 1'b0;
  assign led_o.cheri  = cheri_en_i;
  assign led_o.legacy = ~cheri_en_i;

  // Flash WP and HOLD are active low and never used
  assign flash_wp_n_o   = 1'b1;
  assign flash_hold_n_o = 1'b1;

  assign rgbled_o = ~rgbled_dout_i;  // Level shifter on the board inverts

endmodule

// File: design/board_rst_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Board reset control: PLL-gated saturating hold counter and a two-flop
// release synchronizer producing the system reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sonata_io_cfg.svh"

module board_rst_ctrl (
  input  logic clk_sys_i,
  input  logic arst_n_i,      // Board reset button
  input  logic pll_locked_i,
  output logic rst_sys_n_o
);

  logic [31:0] hold_cnt_q;
  logic        rst_raw_n;
  logic [1:0]  sync_q;

  // Raw reset releases once the hold count is reached
  assign rst_raw_n = (hold_cnt_q == `SONATA_RST_HOLD);

  // Count locked cycles, restart whenever lock is lost
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_cnt_q <= '0;
    end else if (!pll_locked_i) begin
      hold_cnt_q <= '0;
    end else if (!rst_raw_n) begin
      hold_cnt_q <= hold_cnt_q + 32'd1;  // Saturates at the hold value
    end
  end

  // Release goes through two flops; loss of lock asserts at once
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else if (!pll_locked_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], rst_raw_n};
    end
  end

  assign rst_sys_n_o = sync_q[1];

  // System must be in reset on the edge after lock was seen low
  a_rst_on_unlock: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    !pll_locked_i |=> !rst_sys_n_o
  ) else $error("System reset released after PLL lock loss");

  a_cnt_bound: assert property (
    @(posedge clk_sys_i) disable iff (!arst_n_i)
    hold_cnt_q <= `SONATA_RST_HOLD
  ) else $error("Reset hold counter above its limit");

endmodule

// File: design/padring.sv
////////////////////////////////////////////////////////////////////////////
// Bank of tristate bidirectional pads for the shared header pins
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module padring #(
  parameter int unsigned InoutNumber = 1
) (
  input  logic [InoutNumber-1:0] inout_to_pins_i,
  input  logic [InoutNumber-1:0] inout_to_pins_en_i,
  output logic [InoutNumber-1:0] inout_from_pins_o,
  inout  wire  [InoutNumber-1:0] inout_pins_io
);

  for (genvar i = 0; i < InoutNumber; i++) begin : g_pad
    // Drive only when enabled, else let the board decide the level
    assign inout_pins_io[i] = inout_to_pins_en_i[i] ? inout_to_pins_i[i] : 1'bz;

    // Readback is always live, also while driving
    assign inout_from_pins_o[i] = inout_pins_io[i];
  end

  // An unknown enable would make the pad state undefined on the board
  always_comb begin
    a_en_known: assert final (!$isunknown(inout_to_pins_en_i))
      else $error("Unknown pad enable in padring");
  end

endmodule

// File: design/pin_out_gate.sv
////////////////////////////////////////////////////////////////////////////
// Dedicated pin gating: outputs masked by their enables, inputs
// collected into one struct for the system
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pin_out_gate (
  input  sonata_io_pkg::out_pins_t out_to_pins_i,
  input  sonata_io_pkg::out_pins_t out_to_pins_en_i,
  output sonata_io_pkg::out_pins_t out_pins_o,
  input  sonata_io_pkg::in_pins_t  in_pins_i,
  output sonata_io_pkg::in_pins_t  in_from_pins_o
);

  // A disabled output is pulled low rather than left floating
  always_comb begin
    // mikroBUS UART and SPI
    out_pins_o.mb7_tx    = out_to_pins_i.mb7_tx    & out_to_pins_en_i.mb7_tx;
    out_pins_o.mb4_copi  = out_to_pins_i.mb4_copi  & out_to_pins_en_i.mb4_copi;
    out_pins_o.mb2_sck   = out_to_pins_i.mb2_sck   & out_to_pins_en_i.mb2_sck;

    // Ethernet MAC
    out_pins_o.eth_sclk  = out_to_pins_i.eth_sclk  & out_to_pins_en_i.eth_sclk;
    out_pins_o.eth_copi  = out_to_pins_i.eth_copi  & out_to_pins_en_i.eth_copi;

    // LCD and flash SPI
    out_pins_o.lcd_clk   = out_to_pins_i.lcd_clk   & out_to_pins_en_i.lcd_clk;
    out_pins_o.lcd_copi  = out_to_pins_i.lcd_copi  & out_to_pins_en_i.lcd_copi;
    out_pins_o.flash_clk = out_to_pins_i.flash_clk & out_to_pins_en_i.flash_clk;
    out_pins_o.flash_d0  = out_to_pins_i.flash_d0  & out_to_pins_en_i.flash_d0;

    // Serial ports
    out_pins_o.rs232_tx  = out_to_pins_i.rs232_tx  & out_to_pins_en_i.rs232_tx;
    out_pins_o.ser1_tx   = out_to_pins_i.ser1_tx   & out_to_pins_en_i.ser1_tx;
    out_pins_o.ser0_tx   = out_to_pins_i.ser0_tx   & out_to_pins_en_i.ser0_tx;
  end

  // Inputs go straight to the system
  always_comb begin
    in_from_pins_o.mb8_rx   = in_pins_i.mb8_rx;
    in_from_pins_o.mb3_cipo = in_pins_i.mb3_cipo;
    in_from_pins_o.eth_cipo = in_pins_i.eth_cipo;
    in_from_pins_o.flash_d1 = in_pins_i.flash_d1;
    in_from_pins_o.rs232_rx = in_pins_i.rs232_rx;
    in_from_pins_o.ser1_rx  = in_pins_i.ser1_rx;
    in_from_pins_o.ser0_rx  = in_pins_i.ser0_rx;
  end

endmodule

// File: design/sonata_io_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types of the board I/O shell: dedicated pins, switches, GPIO output
// word, SPI chip selects, status LEDs and the shared pin vector
////////////////////////////////////////////////////////////////////////////

`include "sonata_io_cfg.svh"

package sonata_io_pkg;

  // Dedicated outputs, one bit per pad
  typedef struct packed {
    logic mb7_tx;     // mikroBUS UART
    logic mb4_copi;   // mikroBUS SPI
    logic mb2_sck;
    logic eth_sclk;
    logic eth_copi;
    logic lcd_clk;
    logic lcd_copi;
    logic flash_clk;
    logic flash_d0;
    logic rs232_tx;
    logic ser1_tx;
    logic ser0_tx;
  } out_pins_t;

  // Dedicated inputs
  typedef struct packed {
    logic mb8_rx;
    logic mb3_cipo;
    logic eth_cipo;
    logic flash_d1;
    logic rs232_rx;
    logic ser1_rx;
    logic ser0_rx;
  } in_pins_t;

  // Raw switch levels, active low on the board
  typedef struct packed {
    logic [4:0] nav;   // Joystick
    logic [7:0] user;
    logic [2:0] sel;   // Software select
  } board_sw_t;

  // GPIO output word from the system, MSB first
  typedef struct packed {
    logic                     mb_rst;
    logic                     eth_rst;
    logic [7:0]               user_led;
    logic                     lcd_backlight;
    logic                     lcd_dc;
    logic                     lcd_rst;
    logic [`SONATA_GPO_W-14:0] spare;   // Former chip-select bits
  } gp_out_t;

  // Controller by line
  typedef logic [`SONATA_SPI_NUM-1:0][`SONATA_SPI_CS_NUM-1:0] spi_cs_t;

  // SPI controller indices as wired on the board
  typedef enum logic [2:0] {
    SPI_FLASH = 3'd0,
    SPI_LCD   = 3'd1,
    SPI_ETH   = 3'd2,
    SPI_RPH0  = 3'd3,   // R-Pi SPI0 and Arduino
    SPI_RPH1  = 3'd4    // R-Pi SPI1 and mikroBUS
  } spi_ctrl_e;

  // Named chip-select pins on the board
  typedef struct packed {
    logic mb_cs;
    logic rph_spi1_ce2;
    logic rph_spi1_ce1;
    logic rph_spi1_ce0;
    logic ard_cs;
    logic rph_ce1;
    logic rph_ce0;
    logic eth_cs;
    logic lcd_cs;
    logic flash_cs;
  } board_cs_t;

  typedef struct packed {
    logic bootok;
    logic halted;
    logic cheri;
    logic legacy;
  } status_led_t;

  typedef logic [`SONATA_INOUT_NUM-1:0] inout_vec_t;

endpackage

// File: design/sonata_io_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the board I/O shell: reset control, dedicated pin
// gating, shared pad bank and GPIO mapping
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sonata_io_cfg.svh"

module sonata_io_top (
  input  logic                            clk_sys_i,
  input  logic                            arst_n_i,
  input  logic                            pll_locked_i,

  // System side
  input  sonata_io_pkg::gp_out_t          gp_o_i,
  input  sonata_io_pkg::out_pins_t        out_to_pins_i,
  input  sonata_io_pkg::out_pins_t        out_to_pins_en_i,
  input  sonata_io_pkg::inout_vec_t       inout_to_pins_i,
  input  sonata_io_pkg::inout_vec_t       inout_to_pins_en_i,
  input  sonata_io_pkg::spi_cs_t          spi_cs_i,
  input  logic                            cheri_en_i,
  input  logic                            rgbled_dout_i,
  output logic [`SONATA_GPI_W-1:0]        gp_i_o,
  output sonata_io_pkg::in_pins_t         in_from_pins_o,
  output sonata_io_pkg::inout_vec_t       inout_from_pins_o,
  output logic                            rst_sys_n_o,

  // Board side
  output sonata_io_pkg::out_pins_t        out_pins_o,
  input  sonata_io_pkg::in_pins_t         in_pins_i,
  inout  wire  [`SONATA_INOUT_NUM-1:0]    inout_pins_io,
  input  sonata_io_pkg::board_sw_t        sw_n_i,
  input  logic                            mb_int_i,
  output sonata_io_pkg::board_cs_t        cs_pins_o,
  output sonata_io_pkg::status_led_t      led_o,
  output logic [7:0]                      user_led_o,
  output logic [2:0]                      lcd_ctrl_o,
  output logic                            eth_rst_o,
  output logic                            mb_rst_o,
  output logic                            flash_wp_n_o,
  output logic                            flash_hold_n_o,
  output logic                            rgbled_o
);

  // Only sequential part of the shell
  board_rst_ctrl u_board_rst_ctrl (
    .clk_sys_i    (clk_sys_i),
    .arst_n_i     (arst_n_i),
    .pll_locked_i (pll_locked_i),
    .rst_sys_n_o  (rst_sys_n_o)
  );

  pin_out_gate u_pin_out_gate (
    .out_to_pins_i    (out_to_pins_i),
    .out_to_pins_en_i (out_to_pins_en_i),
    .out_pins_o       (out_pins_o),
    .in_pins_i        (in_pins_i),
    .in_from_pins_o   (in_from_pins_o)
  );

  // Shared header pins
  padring #(
    .InoutNumber (`SONATA_INOUT_NUM)
  ) u_padring (
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .inout_from_pins_o  (inout_from_pins_o),
    .inout_pins_io      (inout_pins_io)
  );

  board_gpio_map u_board_gpio_map (
    .sw_n_i         (sw_n_i),
    .mb_int_i       (mb_int_i),
    .gp_o_i         (gp_o_i),
    .spi_cs_i       (spi_cs_i),
    .cheri_en_i     (cheri_en_i),
    .rgbled_dout_i  (rgbled_dout_i),
    .rst_sys_n_i    (rst_sys_n_o),    // Drives the boot-OK LED
    .gp_i_o         (gp_i_o),
    .cs_pins_o      (cs_pins_o),
    .led_o          (led_o),
    .user_led_o     (user_led_o),
    .lcd_ctrl_o     (lcd_ctrl_o),
    .eth_rst_o      (eth_rst_o),
    .mb_rst_o       (mb_rst_o),
    .flash_wp_n_o   (flash_wp_n_o),
    .flash_hold_n_o (flash_hold_n_o),
    .rgbled_o       (rgbled_o)
  );

endmodule

// File: include/sonata_io_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Build-time configuration of the board I/O shell: reset hold length,
// shared pin count, SPI chip-select geometry and GPIO word widths
////////////////////////////////////////////////////////////////////////////

`ifndef SONATA_IO_CFG_SVH
`define SONATA_IO_CFG_SVH

// Locked clock cycles before the raw reset releases
`define SONATA_RST_HOLD 32'd16

// Shared bidirectional header pins
`define SONATA_INOUT_NUM 24

// SPI controllers and chip-select lines per controller
`define SONATA_SPI_NUM 5
`define SONATA_SPI_CS_NUM 4

// GPIO output word, split into LEDs, LCD and reset lines
`define SONATA_GPO_W 16

// GPIO input word seen by the system
`define SONATA_GPI_W 32

`endif

// File: sonata_io.f
+incdir+include
design/sonata_io_pkg.sv
design/board_rst_ctrl.sv
design/pin_out_gate.sv
design/padring.sv
design/board_gpio_map.sv
design/sonata_io_top.sv
testbench/tb_sonata_io.sv

// File: testbench/tb_sonata_io.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the board I/O shell: clock, reset, random stimulus,
// reference model of the pin mapping and typed compare tasks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sonata_io_cfg.svh"

module tb_sonata_io;
  import sonata_io_pkg::*;

  localparam int RelEdges   = `SONATA_RST_HOLD + 2;  // Edges from first lock to release
  localparam int RandCycles = 200;

  logic clk_sys;
  logic arst_n;
  logic pll_locked;

  gp_out_t     gpo_word;
  out_pins_t   out_to_pins, out_to_pins_en, out_pins;
  in_pins_t    in_pins, in_from_pins;
  inout_vec_t  inout_to_pins, inout_to_pins_en, inout_from_pins;
  inout_vec_t  pad_drv_en, pad_drv_val;     // Board-side forcing of shared pins
  spi_cs_t     spi_cs;
  board_sw_t   sw_n;
  board_cs_t   cs_pins;
  status_led_t leds;
  logic        cheri_en, rgbled_dout, mb_int, rst_sys_n;
  logic [`SONATA_GPI_W-1:0] gpi_word;
  logic [7:0]  user_led;
  logic [2:0]  lcd_ctrl;
  logic        eth_rst, mb_rst, flash_wp_n, flash_hold_n, rgbled;
  wire  [`SONATA_INOUT_NUM-1:0] inout_pins;

  // Header pins as the board sees them
  for (genvar i = 0; i < `SONATA_INOUT_NUM; i++) begin : g_board_pin
    pulldown (inout_pins[i]);
    assign inout_pins[i] = pad_drv_en[i] ? pad_drv_val[i] : 1'bz;
  end

  sonata_io_top i_sonata_io_top (
    .clk_sys_i (clk_sys), .arst_n_i (arst_n), .pll_locked_i (pll_locked),
    .gp_o_i (gpo_word), .out_to_pins_i (out_to_pins), .out_to_pins_en_i (out_to_pins_en),
    .inout_to_pins_i (inout_to_pins), .inout_to_pins_en_i (inout_to_pins_en),
    .spi_cs_i (spi_cs), .cheri_en_i (cheri_en), .rgbled_dout_i (rgbled_dout),
    .gp_i_o (gpi_word), .in_from_pins_o (in_from_pins),
    .inout_from_pins_o (inout_from_pins), .rst_sys_n_o (rst_sys_n),
    .out_pins_o (out_pins), .in_pins_i (in_pins), .inout_pins_io (inout_pins),
    .sw_n_i (sw_n), .mb_int_i (mb_int), .cs_pins_o (cs_pins), .led_o (leds),
    .user_led_o (user_led), .lcd_ctrl_o (lcd_ctrl), .eth_rst_o (eth_rst),
    .mb_rst_o (mb_rst), .flash_wp_n_o (flash_wp_n), .flash_hold_n_o (flash_hold_n),
    .rgbled_o (rgbled)
  );

  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;  // 20 ns period
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic report_timeout(input string msg);
    $display("Timed out while %s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopped on timeout");
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_out_pins(input out_pins_t got, input out_pins_t exp);
    if (got !== exp) report_error($sformatf("out_pins got %h expected %h", got, exp));
  endtask

  task automatic check_in_pins(input in_pins_t got, input in_pins_t exp);
    if (got !== exp) report_error($sformatf("in_from_pins got %h expected %h", got, exp));
  endtask

  task automatic check_inout(input inout_vec_t got, input inout_vec_t exp);
    if (got !== exp) report_error($sformatf("inout_from_pins got %h expected %h", got, exp));
  endtask

  task automatic check_gpi(input logic [`SONATA_GPI_W-1:0] got,
                           input logic [`SONATA_GPI_W-1:0] exp);
    if (got !== exp) report_error($sformatf("gp_i got %h expected %h", got, exp));
  endtask

  // Output word as seen on the board pins, spare bits have no pin
  task automatic check_gpo(input gp_out_t got, input gp_out_t exp);
    if (got !== exp) report_error($sformatf("GPIO output pins got %h expected %h", got, exp));
  endtask

  task automatic check_cs(input board_cs_t got, input board_cs_t exp);
    if (got !== exp) report_error($sformatf("cs_pins got %h expected %h", got, exp));
  endtask

  task automatic check_leds(input status_led_t got, input status_led_t exp);
    if (got !== exp) report_error($sformatf("led got %b expected %b", got, exp));
  endtask

  // Switches close to ground, interrupt sits between user and sel
  function automatic logic [`SONATA_GPI_W-1:0] model_gpi(board_sw_t sw, logic irq);
    logic [`SONATA_GPI_W-1:0] w;
    w = '0;
    w[4:0]   = ~sw.nav;
    w[12:5]  = ~sw.user;
    w[13]    = irq;
    w[16:14] = ~sw.sel;
    return w;
  endfunction

  function automatic board_cs_t model_cs(spi_cs_t cs);
    board_cs_t b;
    b.flash_cs     = cs[0][0];
    b.lcd_cs       = cs[1][0];
    b.eth_cs       = cs[2][0];
    b.rph_ce0      = cs[3][0];
    b.rph_ce1      = cs[3][1];
    b.ard_cs       = cs[3][2];
    b.rph_spi1_ce0 = cs[4][0];
    b.rph_spi1_ce1 = cs[4][1];
    b.rph_spi1_ce2 = cs[4][2];
    b.mb_cs        = cs[4][3];
    return b;
  endfunction

  function automatic inout_vec_t model_pads(inout_vec_t val, inout_vec_t en,
                                            inout_vec_t f_en, inout_vec_t f_val);
    inout_vec_t p;
    for (int i = 0; i < `SONATA_INOUT_NUM; i++) begin
      p[i] = en[i] ? val[i] : (f_en[i] ? f_val[i] : 1'b0);  // Pull-down otherwise
    end
    return p;
  endfunction

  function automatic status_led_t model_leds(logic rst_n, logic cheri);
    status_led_t l;
    l.bootok = rst_n;
    l.halted = 1'b0;
    l.cheri  = cheri;
    l.legacy = ~cheri;
    return l;
  endfunction

  // Called between edges with the system in reset; counts edges to release
  task automatic wait_for_release(input int max_edges, output int edges);
    edges = 0;
    while (rst_sys_n !== 1'b1) begin
      if (edges >= max_edges) report_timeout("waiting for system reset release");
      check_bit("bootok under reset", leds.bootok, 1'b0);
      @(posedge clk_sys);
      @(negedge clk_sys);
      edges++;
    end
  endtask

  task automatic check_outputs(input logic exp_rst_n);
    gp_out_t got_gpo;
    gp_out_t exp_gpo;
    got_gpo = '0;
    got_gpo.mb_rst        = mb_rst;
    got_gpo.eth_rst       = eth_rst;
    got_gpo.user_led      = user_led;
    got_gpo.lcd_backlight = lcd_ctrl[2];
    got_gpo.lcd_dc        = lcd_ctrl[1];
    got_gpo.lcd_rst       = lcd_ctrl[0];
    exp_gpo       = gpo_word;
    exp_gpo.spare = '0;
    check_bit("rst_sys_n", rst_sys_n, exp_rst_n);
    check_out_pins(out_pins, out_to_pins & out_to_pins_en);
    check_in_pins(in_from_pins, in_pins);
    check_inout(inout_from_pins,
                model_pads(inout_to_pins, inout_to_pins_en, pad_drv_en, pad_drv_val));
    check_gpi(gpi_word, model_gpi(sw_n, mb_int));
    check_gpo(got_gpo, exp_gpo);
    check_cs(cs_pins, model_cs(spi_cs));
    check_leds(leds, model_leds(exp_rst_n, cheri_en));
    check_bit("flash_wp_n", flash_wp_n, 1'b1);
    check_bit("flash_hold_n", flash_hold_n, 1'b1);
    check_bit("rgbled", rgbled, ~rgbled_dout);
  endtask

  task automatic run_random_cycle();
    logic [31:0] r [6];
    @(posedge clk_sys);
    #2;
    for (int k = 0; k < 6; k++) r[k] = $urandom();
    out_to_pins      = out_pins_t'(r[0][11:0]);
    out_to_pins_en   = out_pins_t'(r[0][23:12]);
    in_pins          = in_pins_t'(r[0][30:24]);
    inout_to_pins    = r[1][23:0];
    cheri_en         = r[1][24];
    rgbled_dout      = r[1][25];
    mb_int           = r[1][26];
    inout_to_pins_en = r[2][23:0];
    pad_drv_en       = r[3][23:0] & ~r[2][23:0];  // Never fight an enabled pad
    pad_drv_val      = r[4][23:0];
    sw_n             = board_sw_t'(r[5][15:0]);
    gpo_word         = gp_out_t'(r[4][31:24] ^ r[5][31:16]);
    spi_cs           = spi_cs_t'({r[3][31:24], r[2][31:24], r[1][31:28]});
    @(negedge clk_sys);
    check_outputs(1'b1);
  endtask

  initial begin : main
    int unsigned seed_ret;
    int edges;
    seed_ret = $urandom(32'h39d2_f050);
    arst_n = 1'b0;
    pll_locked = 1'b1;
    gpo_word = '0;
    out_to_pins = '0;
    out_to_pins_en = '0;
    in_pins = '0;
    inout_to_pins = '0;
    inout_to_pins_en = '0;
    pad_drv_en = '0;
    pad_drv_val = '0;
    spi_cs = '0;
    sw_n = '1;        // All switches open
    mb_int = 1'b0;
    cheri_en = 1'b0;
    rgbled_dout = 1'b0;

    // Board reset button held for 4 cycles
    repeat (4) @(posedge clk_sys);
    @(negedge clk_sys);
    check_outputs(1'b0);
    @(posedge clk_sys);
    #2;
    arst_n = 1'b1;

    wait_for_release(RelEdges + 8, edges);
    if (edges != RelEdges)
      report_error($sformatf("reset released after %0d edges, expected %0d", edges, RelEdges));
    check_leds(leds, model_leds(1'b1, cheri_en));

    // Lock loss asserts reset on the next edge
    @(posedge clk_sys);
    #2;
    pll_locked = 1'b0;
    @(negedge clk_sys);
    check_bit("rst_sys_n before unlock edge", rst_sys_n, 1'b1);
    repeat (3) begin
      @(negedge clk_sys);
      check_outputs(1'b0);
    end
    @(posedge clk_sys);
    #2;
    pll_locked = 1'b1;
    wait_for_release(RelEdges + 8, edges);
    if (edges != RelEdges)
      report_error($sformatf("relock release after %0d edges, expected %0d", edges, RelEdges));

    repeat (RandCycles) run_random_cycle();

    // All pads released and nothing forced, pull-downs win
    @(posedge clk_sys);
    #2;
    inout_to_pins_en = '0;
    pad_drv_en = '0;
    @(negedge clk_sys);
    check_inout(inout_from_pins, '0);

    $display("=== PASS ===");
    $finish;
  end

endmodule
